/* verilog/usb_ep_pkg.sv */
`default_nettype none

package usb_ep_pkg;

  localparam int BYTE_W = 8;  // Stream data byte
  localparam int ENDP_W = 4;  // USB endpoint number

  localparam logic [ENDP_W-1:0] DATA_ENDPOINT = 4'd1;  // User bulk IN
  localparam logic [ENDP_W-1:0] TELE_ENDPOINT = 4'd2;  // Telemetry bulk IN

  // Telemetry queue geometry
  localparam int TELE_DEPTH        = 16;
  localparam int TELE_LEVEL_W      = 5;  // Holds 0 to TELE_DEPTH
  localparam int TELE_PACKET_WORDS = 8;
  localparam int TELE_BYTES        = 4;

  localparam int RST_STAGES = 4;  // Core reset synchronizer length

  // Snapshot taken on each high-speed SOF
  typedef struct packed {
    logic [1:0]  line_state;
    logic        high_speed;
    logic [4:0]  timeout_cnt;  // Saturating
    logic [7:0]  crc_cnt;      // Saturating
    logic [15:0] sof_cnt;      // Wrapping
  } tele_word_t;

  typedef enum logic {
    SRC_USER = 1'b0,
    SRC_TELE = 1'b1
  } in_src_e;

endpackage

`default_nettype wire

/* verilog/axis_byte_if.sv */
`default_nettype none

interface axis_byte_if;
  import usb_ep_pkg::*;

  logic              tvalid;
  logic              tready;
  logic              tlast;
  logic              tkeep;
  logic [BYTE_W-1:0] tdata;

  modport source (
    output tvalid, tlast, tkeep, tdata,
    input  tready
  );

  modport sink (
    input  tvalid, tlast, tkeep, tdata,
    output tready
  );

endinterface

`default_nettype wire

/* verilog/link_status.sv */
`default_nettype none

module link_status (
  input  logic                   clock,
  input  logic                   areset_n,
  input  logic                   usb_reset_i,
  input  logic                   high_speed_i,
  input  logic [1:0]             line_state_i,
  input  logic                   usb_sof_i,
  input  logic                   crc_err_i,
  input  logic                   timeout_i,
  output logic                   usb_reset_o,
  output usb_ep_pkg::tele_word_t word_o,
  output logic                   capture_o
);
  import usb_ep_pkg::*;

  logic [RST_STAGES-1:0] rst_n_q;
  logic [15:0] sof_cnt_q, sof_cnt_d;
  logic [7:0]  crc_cnt_q, crc_cnt_d;
  logic [4:0]  tout_cnt_q, tout_cnt_d;

  // Bus reset knocks out the final stage only
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      rst_n_q <= '0;
    end else begin
      rst_n_q <= {rst_n_q[RST_STAGES-2] & ~usb_reset_i, rst_n_q[RST_STAGES-3:0], 1'b1};
    end
  end

  assign usb_reset_o = ~rst_n_q[RST_STAGES-1];

  always_comb begin
    sof_cnt_d  = usb_sof_i ? sof_cnt_q + 16'd1 : sof_cnt_q;  // Wraps
    crc_cnt_d  = (crc_err_i && crc_cnt_q != '1) ? crc_cnt_q + 8'd1 : crc_cnt_q;
    tout_cnt_d = (timeout_i && tout_cnt_q != '1) ? tout_cnt_q + 5'd1 : tout_cnt_q;
  end

  always_ff @(posedge clock) begin
    if (usb_reset_o) begin
      sof_cnt_q  <= '0;
      crc_cnt_q  <= '0;
      tout_cnt_q <= '0;
    end else begin
      sof_cnt_q  <= sof_cnt_d;
      crc_cnt_q  <= crc_cnt_d;
      tout_cnt_q <= tout_cnt_d;
    end
  end

  // Snapshot carries this cycle's events already counted
  always_comb begin
    word_o.line_state  = line_state_i;
    word_o.high_speed  = high_speed_i;
    word_o.timeout_cnt = tout_cnt_d;
    word_o.crc_cnt     = crc_cnt_d;
    word_o.sof_cnt     = sof_cnt_d;
  end

  assign capture_o = usb_sof_i & high_speed_i;

endmodule

`default_nettype wire

/* verilog/telemetry_capture.sv */
`default_nettype none

module telemetry_capture (
  input  logic                                clock,
  input  logic                                usb_reset_i,
  input  usb_ep_pkg::tele_word_t              word_i,
  input  logic                                capture_i,
  output logic [usb_ep_pkg::TELE_LEVEL_W-1:0] level_o,
  output logic                                has_word_o,
  axis_byte_if.source                         tele_bus
);
  import usb_ep_pkg::*;

  tele_word_t fifo_mem [TELE_DEPTH];

  logic [$clog2(TELE_DEPTH)-1:0]        wr_ptr_q;
  logic [$clog2(TELE_DEPTH)-1:0]        rd_ptr_q;
  logic [TELE_LEVEL_W-1:0]              level_q;
  logic [$clog2(TELE_BYTES)-1:0]        byte_idx_q;  // Byte within head word
  logic [$clog2(TELE_PACKET_WORDS)-1:0] word_idx_q;  // Word within packet
  logic [TELE_BYTES*BYTE_W-1:0]         head_bits;
  logic                                 push;
  logic                                 pop;
  logic                                 byte_fire;

  // Captures that arrive while full are lost
  assign push      = capture_i && (level_q != TELE_LEVEL_W'(TELE_DEPTH));
  assign byte_fire = tele_bus.tvalid && tele_bus.tready;
  assign pop       = byte_fire && (&byte_idx_q);  // Last byte of the head word

  always_ff @(posedge clock) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= word_i;
    end
  end

  always_ff @(posedge clock) begin
    if (usb_reset_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_q    <= '0;
      byte_idx_q <= '0;
      word_idx_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q   <= rd_ptr_q + 1'b1;
        word_idx_q <= word_idx_q + 1'b1;
      end
      if (byte_fire) begin
        byte_idx_q <= byte_idx_q + 1'b1;
      end

      if (push && !pop) begin
        level_q <= level_q + 1'b1;
      end else if (pop && !push) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

  assign head_bits = fifo_mem[rd_ptr_q];

  // Serializer sends the least significant byte first
  assign tele_bus.tvalid = (level_q != '0);
  assign tele_bus.tdata  = head_bits[byte_idx_q*BYTE_W +: BYTE_W];
  assign tele_bus.tlast  = (&byte_idx_q) && (&word_idx_q);  // End of packet
  assign tele_bus.tkeep  = tele_bus.tvalid;

  assign level_o    = level_q;
  assign has_word_o = (level_q != '0);

endmodule

`default_nettype wire

/* verilog/bulk_in_arbiter.sv */
`default_nettype none

module bulk_in_arbiter (
  input  logic                                clock,
  input  logic                                usb_reset_i,
  input  logic                                high_speed_i,
  input  logic [usb_ep_pkg::ENDP_W-1:0]       blk_endpt_i,
  input  logic                                blk_fetch_i,
  input  logic                                blk_in_ready_i,
  input  logic [usb_ep_pkg::TELE_LEVEL_W-1:0] tele_level_i,
  output logic                                blk_in_ready_o,
  input  logic                                s_axis_tvalid_i,
  input  logic                                s_axis_tlast_i,
  input  logic                                s_axis_tkeep_i,
  input  logic [usb_ep_pkg::BYTE_W-1:0]       s_axis_tdata_i,
  output logic                                s_axis_tready_o,
  axis_byte_if.sink                           tele_bus,
  axis_byte_if.source                         mux_bus
);
  import usb_ep_pkg::*;

  in_src_e src_q;
  logic    blk_in_ready_q;
  logic    ready_d;
  logic    tele_sel;

  // Telemetry only counts once a whole packet is queued
  always_comb begin
    ready_d = 1'b0;
    if (high_speed_i) begin
      if (blk_endpt_i == DATA_ENDPOINT && blk_in_ready_i) begin
        ready_d = 1'b1;
      end else if (blk_endpt_i == TELE_ENDPOINT &&
                   tele_level_i >= TELE_LEVEL_W'(TELE_PACKET_WORDS)) begin
        ready_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (usb_reset_i) begin
      src_q          <= SRC_USER;
      blk_in_ready_q <= 1'b0;
    end else begin
      src_q          <= (blk_endpt_i == TELE_ENDPOINT) ? SRC_TELE : SRC_USER;
      blk_in_ready_q <= ready_d;
    end
  end

  assign tele_sel       = (src_q == SRC_TELE);
  assign blk_in_ready_o = blk_in_ready_q;

  assign mux_bus.tvalid = tele_sel ? tele_bus.tvalid : (blk_fetch_i & s_axis_tvalid_i);
  assign mux_bus.tlast  = tele_sel ? tele_bus.tlast : s_axis_tlast_i;
  assign mux_bus.tkeep  = tele_sel ? tele_bus.tkeep : s_axis_tkeep_i;
  assign mux_bus.tdata  = tele_sel ? tele_bus.tdata : s_axis_tdata_i;

  // Ready only goes back to the selected source
  assign tele_bus.tready = tele_sel & mux_bus.tready;
  assign s_axis_tready_o = blk_fetch_i & ~tele_sel & mux_bus.tready;

endmodule

`default_nettype wire

/* verilog/axis_skid.sv */
`default_nettype none

module axis_skid (
  input  logic                          clock,
  input  logic                          usb_reset_i,
  axis_byte_if.sink                     in_bus,
  output logic                          m_axis_tvalid_o,
  input  logic                          m_axis_tready_i,
  output logic                          m_axis_tlast_o,
  output logic                          m_axis_tkeep_o,
  output logic [usb_ep_pkg::BYTE_W-1:0] m_axis_tdata_o
);
  import usb_ep_pkg::*;

  logic              main_valid_q, skid_valid_q, ready_q;
  logic              main_last_q, main_keep_q, skid_last_q, skid_keep_q;
  logic [BYTE_W-1:0] main_data_q, skid_data_q;
  logic              in_fire, main_free;

  assign in_fire   = in_bus.tvalid & ready_q;
  assign main_free = ~main_valid_q | m_axis_tready_i;  // Output empties this cycle

  always_ff @(posedge clock) begin
    if (usb_reset_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_q      <= 1'b0;
    end else if (main_free) begin
      main_valid_q <= skid_valid_q | in_fire;
      skid_valid_q <= 1'b0;
      ready_q      <= 1'b1;
    end else if (in_fire) begin
      skid_valid_q <= 1'b1;  // Second entry fills during a stall
      ready_q      <= 1'b0;
    end
  end

  // Older byte always leaves the payload registers first
  always_ff @(posedge clock) begin
    if (main_free) begin
      main_data_q <= skid_valid_q ? skid_data_q : in_bus.tdata;
      main_last_q <= skid_valid_q ? skid_last_q : in_bus.tlast;
      main_keep_q <= skid_valid_q ? skid_keep_q : in_bus.tkeep;
    end else if (in_fire) begin
      skid_data_q <= in_bus.tdata;
      skid_last_q <= in_bus.tlast;
      skid_keep_q <= in_bus.tkeep;
    end
  end

  assign in_bus.tready   = ready_q;
  assign m_axis_tvalid_o = main_valid_q;
  assign m_axis_tlast_o  = main_last_q;
  assign m_axis_tkeep_o  = main_keep_q;
  assign m_axis_tdata_o  = main_data_q;

endmodule

`default_nettype wire

/* verilog/usb_ep_bridge.sv */
`default_nettype none

module usb_ep_bridge (
  input  logic                          clock,
  input  logic                          areset_n,
  input  logic                          usb_reset_i,
  output logic                          usb_reset_o,
  input  logic                          high_speed_i,
  input  logic [1:0]                    line_state_i,
  input  logic                          usb_sof_i,
  input  logic                          crc_err_i,
  input  logic                          timeout_i,
  output logic                          has_telemetry_o,
  input  logic [usb_ep_pkg::ENDP_W-1:0] blk_endpt_i,
  input  logic                          blk_fetch_i,
  input  logic                          blk_in_ready_i,
  output logic                          blk_in_ready_o,
  input  logic                          s_axis_tvalid_i,
  output logic                          s_axis_tready_o,
  input  logic                          s_axis_tlast_i,
  input  logic                          s_axis_tkeep_i,
  input  logic [usb_ep_pkg::BYTE_W-1:0] s_axis_tdata_i,
  output logic                          m_axis_tvalid_o,
  input  logic                          m_axis_tready_i,
  output logic                          m_axis_tlast_o,
  output logic                          m_axis_tkeep_o,
  output logic [usb_ep_pkg::BYTE_W-1:0] m_axis_tdata_o
);
  import usb_ep_pkg::*;

  tele_word_t              tele_word;
  logic                    tele_capture;
  logic [TELE_LEVEL_W-1:0] tele_level;

  axis_byte_if tele_bus ();  // Telemetry bytes to the arbiter
  axis_byte_if mux_bus ();   // Selected IN stream to the skid buffer

  link_status u_link_status (
    .clock        (clock),
    .areset_n     (areset_n),
    .usb_reset_i  (usb_reset_i),
    .high_speed_i (high_speed_i),
    .line_state_i (line_state_i),
    .usb_sof_i    (usb_sof_i),
    .crc_err_i    (crc_err_i),
    .timeout_i    (timeout_i),
    .usb_reset_o  (usb_reset_o),
    .word_o       (tele_word),
    .capture_o    (tele_capture)
  );

  telemetry_capture u_telemetry_capture (
    .clock       (clock),
    .usb_reset_i (usb_reset_o),
    .word_i      (tele_word),
    .capture_i   (tele_capture),
    .level_o     (tele_level),
    .has_word_o  (has_telemetry_o),
    .tele_bus    (tele_bus)
  );

  bulk_in_arbiter u_bulk_in_arbiter (
    .clock           (clock),
    .usb_reset_i     (usb_reset_o),
    .high_speed_i    (high_speed_i),
    .blk_endpt_i     (blk_endpt_i),
    .blk_fetch_i     (blk_fetch_i),
    .blk_in_ready_i  (blk_in_ready_i),
    .tele_level_i    (tele_level),
    .blk_in_ready_o  (blk_in_ready_o),
    .s_axis_tvalid_i (s_axis_tvalid_i),
    .s_axis_tlast_i  (s_axis_tlast_i),
    .s_axis_tkeep_i  (s_axis_tkeep_i),
    .s_axis_tdata_i  (s_axis_tdata_i),
    .s_axis_tready_o (s_axis_tready_o),
    .tele_bus        (tele_bus),
    .mux_bus         (mux_bus)
  );

  axis_skid u_axis_skid (
    .clock           (clock),
    .usb_reset_i     (usb_reset_o),
    .in_bus          (mux_bus),
    .m_axis_tvalid_o (m_axis_tvalid_o),
    .m_axis_tready_i (m_axis_tready_i),
    .m_axis_tlast_o  (m_axis_tlast_o),
    .m_axis_tkeep_o  (m_axis_tkeep_o),
    .m_axis_tdata_o  (m_axis_tdata_o)
  );

endmodule

`default_nettype wire

/* bench/tb_usb_ep_bridge.sv */
`default_nettype none

module tb_usb_ep_bridge;
  timeunit 1ns;
  timeprecision 100ps;
  import usb_ep_pkg::*;

  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int USER_BYTES      = 200;

  logic              clock;
  logic              areset_n;
  logic              usb_reset_i, usb_reset_o;
  logic              high_speed_i;
  logic [1:0]        line_state_i;
  logic              usb_sof_i, crc_err_i, timeout_i;
  logic              has_telemetry_o;
  logic [ENDP_W-1:0] blk_endpt_i;
  logic              blk_fetch_i, blk_in_ready_i, blk_in_ready_o;
  logic              s_axis_tvalid_i, s_axis_tready_o, s_axis_tlast_i, s_axis_tkeep_i;
  logic [BYTE_W-1:0] s_axis_tdata_i;
  logic              m_axis_tvalid_o, m_axis_tready_i, m_axis_tlast_o, m_axis_tkeep_o;
  logic [BYTE_W-1:0] m_axis_tdata_o;

  logic [31:0] lcg_state;
  logic [9:0]  exp_q[$];  // {tkeep, tlast, tdata} still due on m_axis
  logic [31:0] tele_q[$];  // Words the FIFO should hold
  logic [15:0] ref_sof;
  logic [7:0]  ref_crc;
  logic [4:0]  ref_tout;
  int          tele_bytes_out;  // Telemetry bytes since the last bus reset
  string       test_name;
  logic        stalled = 1'b0;
  logic [9:0]  stall_beat;

  usb_ep_bridge dut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Watchdog
  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clock);
    fail_run("Timeout: the tests did not finish in time");
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at %0t", $time);
  endtask

  task automatic check_val(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (expected === actual)
      else fail_run($sformatf("ERR %s: %s expected %0h actual %0h",
                              test_name, what, expected, actual));
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Bulk IN readiness as the link layer expects it
  function automatic logic ready_rule(input logic hs, input logic [ENDP_W-1:0] ep,
                                      input logic bir, input int level);
    return hs && ((ep == DATA_ENDPOINT && bir) ||
                  (ep == TELE_ENDPOINT && level >= TELE_PACKET_WORDS));
  endfunction

  task automatic expect_quiet();
    check_val("m_axis_tvalid_o", 0, m_axis_tvalid_o);
    check_val("s_axis_tready_o", 0, s_axis_tready_o);
    check_val("blk_in_ready_o", 0, blk_in_ready_o);
    check_val("has_telemetry_o", 0, has_telemetry_o);
  endtask

  // One cycle of link events mirrored in the counter model
  task automatic pulse_events(input logic sof, input logic crc, input logic tout);
    logic [31:0] r;
    r = lcg_next();
    line_state_i = r[25:24];
    usb_sof_i    = sof;
    crc_err_i    = crc;
    timeout_i    = tout;
    if (sof) ref_sof = ref_sof + 16'd1;
    if (crc && ref_crc != 8'hff) ref_crc = ref_crc + 8'd1;
    if (tout && ref_tout != 5'h1f) ref_tout = ref_tout + 5'd1;
    if (sof && high_speed_i && tele_q.size() < TELE_DEPTH) begin
      tele_q.push_back({r[25:24], high_speed_i, ref_tout, ref_crc, ref_sof});
    end
    @(negedge clock);
    usb_sof_i = 1'b0;
    crc_err_i = 1'b0;
    timeout_i = 1'b0;
  endtask

  task automatic probe_ready(input logic hs, input logic [ENDP_W-1:0] ep, input logic bir);
    high_speed_i   = hs;
    blk_endpt_i    = ep;
    blk_in_ready_i = bir;
    @(negedge clock);  // Registered flag settles one cycle later
    check_val("blk_in_ready_o", ready_rule(hs, ep, bir, tele_q.size()), blk_in_ready_o);
  endtask

  task automatic send_user_bytes(input int count);
    logic [31:0] r;
    int          sent;
    logic        taken;
    sent = 0;
    while (sent < count) begin
      r = lcg_next();
      if (!s_axis_tvalid_i && r[31]) begin  // Gaps between bytes now and then
        s_axis_tvalid_i = 1'b1;
        s_axis_tdata_i  = r[23:16];
        s_axis_tlast_i  = r[15];
        s_axis_tkeep_i  = r[14] | r[13];
      end
      m_axis_tready_i = r[30];
      #1;
      taken = s_axis_tvalid_i && s_axis_tready_o;
      if (taken) begin
        exp_q.push_back({s_axis_tkeep_i, s_axis_tlast_i, s_axis_tdata_i});
        sent++;
      end
      @(negedge clock);
      if (taken) s_axis_tvalid_i = 1'b0;
    end
  endtask

  // Reads every queued word over the telemetry endpoint
  task automatic drain_telemetry();
    logic [31:0] r;
    logic [31:0] word;
    int          b;
    foreach (tele_q[w]) begin
      word = tele_q[w];
      for (b = 0; b < TELE_BYTES; b++) begin
        exp_q.push_back({1'b1, ((tele_bytes_out % 32) == 31), word[8*b +: 8]});
        tele_bytes_out++;
      end
    end
    tele_q.delete();
    blk_endpt_i = TELE_ENDPOINT;
    while (exp_q.size() != 0) begin
      r = lcg_next();
      m_axis_tready_i = r[31] | r[30];
      @(negedge clock);
    end
    // Extra bytes after this would be words that should have been dropped
    m_axis_tready_i = 1'b1;
    repeat (8) @(negedge clock);
    check_val("has_telemetry_o", 0, has_telemetry_o);
    blk_endpt_i     = DATA_ENDPOINT;
    m_axis_tready_i = 1'b0;
  endtask

  // Output monitor sampling the values held up to the edge
  always @(posedge clock) begin
    if (stalled) begin
      check_val("m_axis stalled byte", {1'b1, stall_beat},
                {m_axis_tvalid_o, m_axis_tkeep_o, m_axis_tlast_o, m_axis_tdata_o});
    end
    stalled    = m_axis_tvalid_o && !m_axis_tready_i;
    stall_beat = {m_axis_tkeep_o, m_axis_tlast_o, m_axis_tdata_o};
    if (m_axis_tvalid_o && m_axis_tready_i) begin
      if (exp_q.size() == 0) begin
        fail_run("m_axis delivered a byte that nobody sent");
      end else begin
        check_val("m_axis byte", exp_q.pop_front(), stall_beat);
      end
    end
  end

  initial begin
    int i;
    lcg_state       = 32'h3b4b_c13c;
    areset_n        = 1'b0;
    usb_reset_i     = 1'b0;
    high_speed_i    = 1'b0;
    line_state_i    = 2'b00;
    usb_sof_i       = 1'b0;
    crc_err_i       = 1'b0;
    timeout_i       = 1'b0;
    blk_endpt_i     = DATA_ENDPOINT;
    blk_fetch_i     = 1'b0;
    blk_in_ready_i  = 1'b0;
    s_axis_tvalid_i = 1'b0;
    s_axis_tlast_i  = 1'b0;
    s_axis_tkeep_i  = 1'b0;
    s_axis_tdata_i  = '0;
    m_axis_tready_i = 1'b0;
    ref_sof         = '0;
    ref_crc         = '0;
    ref_tout        = '0;
    tele_bytes_out  = 0;

    test_name = "reset";
    repeat (2) begin
      @(negedge clock);
      check_val("usb_reset_o", 1, usb_reset_o);
      expect_quiet();
    end
    areset_n = 1'b1;
    for (i = 1; i <= 6; i++) begin
      @(negedge clock);
      check_val("usb_reset_o", (i < RST_STAGES), usb_reset_o);  // Low from the 4th edge
      expect_quiet();
    end

    test_name    = "user bulk IN";
    high_speed_i = 1'b1;
    blk_fetch_i  = 1'b1;
    send_user_bytes(USER_BYTES);
    m_axis_tready_i = 1'b1;
    while (exp_q.size() != 0) @(negedge clock);
    blk_fetch_i     = 1'b0;
    m_axis_tready_i = 1'b0;

    test_name = "readiness";
    probe_ready(1'b1, DATA_ENDPOINT, 1'b1);
    probe_ready(1'b1, DATA_ENDPOINT, 1'b0);
    probe_ready(1'b0, DATA_ENDPOINT, 1'b1);
    probe_ready(1'b1, TELE_ENDPOINT, 1'b1);  // Empty FIFO
    probe_ready(1'b1, 4'd3, 1'b1);
    // Ten SOFs with CRC and timeout events on fixed cycles
    for (i = 0; i < 10; i++) begin
      pulse_events(1'b0, (i % 3 == 0), 1'b0);
      pulse_events(1'b1, (i % 2 == 1), (i % 4 == 0));
      if (i == 6) probe_ready(1'b1, TELE_ENDPOINT, 1'b0);  // One word short
      if (i == 7) begin
        probe_ready(1'b0, TELE_ENDPOINT, 1'b0);
        probe_ready(1'b1, TELE_ENDPOINT, 1'b0);
      end
    end

    test_name    = "telemetry content";
    high_speed_i = 1'b1;
    drain_telemetry();

    test_name = "overflow and bus reset";
    for (i = 0; i < 20; i++) begin
      pulse_events(1'b1, (i % 5 == 0), 1'b1);
      pulse_events(1'b0, 1'b0, 1'b1);  // Timeout count saturates
    end
    check_val("has_telemetry_o", 1, has_telemetry_o);
    probe_ready(1'b1, TELE_ENDPOINT, 1'b0);
    drain_telemetry();
    pulse_events(1'b1, 1'b1, 1'b0);
    pulse_events(1'b1, 1'b0, 1'b1);
    check_val("has_telemetry_o", 1, has_telemetry_o);
    usb_reset_i = 1'b1;
    @(negedge clock);
    check_val("usb_reset_o", 1, usb_reset_o);
    usb_reset_i = 1'b0;
    @(negedge clock);
    check_val("usb_reset_o", 0, usb_reset_o);
    expect_quiet();
    ref_sof        = '0;
    ref_crc        = '0;
    ref_tout       = '0;
    tele_bytes_out = 0;
    tele_q.delete();
    pulse_events(1'b1, 1'b1, 1'b0);  // First word after the bus reset
    drain_telemetry();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
verilog/usb_ep_pkg.sv
verilog/axis_byte_if.sv
verilog/link_status.sv
verilog/telemetry_capture.sv
verilog/bulk_in_arbiter.sv
verilog/axis_skid.sv
verilog/usb_ep_bridge.sv
bench/tb_usb_ep_bridge.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_usb_ep_bridge -f flist.f -o sim_tb_usb_ep_bridge
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit "$build_status"
fi

./obj_dir/sim_tb_usb_ep_bridge
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation failed with status $sim_status"
  exit "$sim_status"
fi
exit 0
